/* hdl/trace_pkg.sv */
package trace_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int XLEN        = 32;  // data and address width
    localparam int TRACE_DEPTH = 8;   // record FIFO entries
    localparam int TRACE_CNT_W = 4;   // holds 0..TRACE_DEPTH
    localparam int TRACE_PTR_W = 3;   // FIFO pointer width

    // execution phase codes, as driven by the core
    localparam logic [2:0] PHA_IF  = 3'b000;  // instruction fetch
    localparam logic [2:0] PHA_RS1 = 3'b101;  // rs1 read
    localparam logic [2:0] PHA_RS2 = 3'b110;  // rs2 read
    localparam logic [2:0] PHA_MLD = 3'b001;  // memory load
    localparam logic [2:0] PHA_MST = 3'b010;  // memory store
    localparam logic [2:0] PHA_EXE = 3'b011;  // branch condition
    localparam logic [2:0] PHA_WB  = 3'b100;  // register write-back

    ////////////////////////////////////////
    // bus structs
    ////////////////////////////////////////

    typedef struct packed {
        logic            vld;
        logic [2:0]      pha;   // execution phase
        logic            wen;
        logic [1:0]      siz;   // log2 of byte count
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] wdt;
    } tcb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdt;   // valid one cycle after the transfer
        logic            rdy;
    } tcb_rsp_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [7:0]      paddr;
        logic [XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    // one retired instruction
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] ins;
        logic            wb_vld;  // register written
        logic [4:0]      wb_idx;
        logic [XLEN-1:0] wb_dat;
        logic            ls_vld;  // memory accessed
        logic            ls_wen;  // store when set
        logic [1:0]      ls_siz;
        logic [XLEN-1:0] ls_adr;
        logic [XLEN-1:0] ls_dat;  // data moved either way
    } trace_rec_t;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    localparam logic [7:0] REG_STATUS = 8'h00;
    localparam logic [7:0] REG_CTRL   = 8'h04;
    localparam logic [7:0] REG_POP    = 8'h08;
    localparam logic [7:0] REG_PC     = 8'h10;
    localparam logic [7:0] REG_INS    = 8'h14;
    localparam logic [7:0] REG_FLAGS  = 8'h18;
    localparam logic [7:0] REG_WB_DAT = 8'h1C;
    localparam logic [7:0] REG_LS_ADR = 8'h20;
    localparam logic [7:0] REG_LS_DAT = 8'h24;

    localparam int CTRL_ENA     = 0;  // trace enable
    localparam int CTRL_OVF_CLR = 1;  // write 1 to clear overflow

endpackage

/* hdl/trace_collector.sv */
`timescale 1ns/1ns

module trace_collector import trace_pkg::*; (
    input  logic       tcb,    // clock
    input  logic       rst_n,
    input  tcb_req_t   req,    // core request, monitored only
    input  tcb_rsp_t   rsp,
    input  logic       ena,    // tracing enabled
    output logic       push,   // record complete
    output trace_rec_t rec
);

    ////////////////////////////////////////
    // transfer capture
    ////////////////////////////////////////

    logic            trn;     // handshake this cycle
    logic            trn_q;   // handshake last cycle
    logic [2:0]      pha_q;
    logic [1:0]      siz_q;
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] wdt_q;

    assign trn = req.vld & rsp.rdy;  // stalled requests are not transfers

    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            trn_q <= 1'b0;
        end else begin
            trn_q <= trn;
        end
    end

    // request fields, only loaded on a real transfer
    always_ff @(posedge tcb) begin
        if (trn) begin
            pha_q <= req.pha;
            siz_q <= req.siz;
            adr_q <= req.adr;
            wdt_q <= req.wdt;
        end
    end

    ////////////////////////////////////////
    // open record
    ////////////////////////////////////////

    logic            rec_open;  // an instruction has been fetched
    logic            wb_vld;
    logic            ls_vld;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] ins_q;
    logic [4:0]      wb_idx_q;
    logic [XLEN-1:0] wb_dat_q;
    logic            ls_wen_q;
    logic [1:0]      ls_siz_q;
    logic [XLEN-1:0] ls_adr_q;
    logic [XLEN-1:0] ls_dat_q;

    // valids and the open flag
    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            rec_open <= 1'b0;
            wb_vld   <= 1'b0;
            ls_vld   <= 1'b0;
        end else if (trn_q) begin
            case (pha_q)
                PHA_IF: begin
                    rec_open <= 1'b1;  // new instruction starts
                    wb_vld   <= 1'b0;
                    ls_vld   <= 1'b0;
                end
                PHA_WB: begin
                    wb_vld <= 1'b1;
                end
                PHA_MLD, PHA_MST: begin
                    ls_vld <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // record payload, rdt is sampled here, the cycle after the transfer
    always_ff @(posedge tcb) begin
        if (trn_q) begin
            case (pha_q)
                PHA_IF: begin
                    pc_q  <= adr_q;
                    ins_q <= rsp.rdt;     // fetched word
                end
                PHA_WB: begin
                    wb_idx_q <= adr_q[6:2];  // register file is bus mapped
                    wb_dat_q <= wdt_q;
                end
                PHA_MLD: begin
                    ls_wen_q <= 1'b0;
                    ls_siz_q <= siz_q;
                    ls_adr_q <= adr_q;
                    ls_dat_q <= rsp.rdt;  // loaded data
                end
                PHA_MST: begin
                    ls_wen_q <= 1'b1;
                    ls_siz_q <= siz_q;
                    ls_adr_q <= adr_q;
                    ls_dat_q <= wdt_q;    // stored data
                end
                PHA_RS1, PHA_RS2, PHA_EXE: begin
                    // operand reads and branch eval are not logged
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // output
    ////////////////////////////////////////

    // the next fetch retires the previous instruction
    assign push = trn_q & (pha_q == PHA_IF) & rec_open & ena;

    always_comb begin
        rec.pc     = pc_q;
        rec.ins    = ins_q;
        rec.wb_vld = wb_vld;
        rec.wb_idx = wb_idx_q;
        rec.wb_dat = wb_dat_q;
        rec.ls_vld = ls_vld;
        rec.ls_wen = ls_wen_q;
        rec.ls_siz = ls_siz_q;
        rec.ls_adr = ls_adr_q;
        rec.ls_dat = ls_dat_q;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // fetch transfers seen on the bus since reset, stops at two
    logic [1:0] if_seen;

    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            if_seen <= '0;
        end else if (trn && req.pha == PHA_IF && if_seen != 2'd2) begin
            if_seen <= if_seen + 1'b1;
        end
    end

    // a push retires an instruction that an earlier fetch opened
    a_push_open: assert property (
        @(posedge tcb) disable iff (!rst_n)
        push |-> if_seen == 2'd2
    ) else $error("push without an open record");

    // core holds the phase through a stall
    a_pha_hold: assert property (
        @(posedge tcb) disable iff (!rst_n)
        req.vld && !rsp.rdy |=> req.vld && $stable(req.pha)
    ) else $error("phase changed during stall");

endmodule

/* hdl/trace_fifo.sv */
`timescale 1ns/1ns

module trace_fifo import trace_pkg::*; (
    input  logic                   tcb,
    input  logic                   rst_n,
    input  logic                   push,
    input  trace_rec_t             rec,
    input  logic                   pop,
    input  logic                   ovf_clr,
    output trace_rec_t             head,      // oldest record
    output logic [TRACE_CNT_W-1:0] count,
    output logic                   overflow   // sticky
);

    trace_rec_t             mem [TRACE_DEPTH];
    logic [TRACE_PTR_W-1:0] wr_ptr;
    logic [TRACE_PTR_W-1:0] rd_ptr;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (count == TRACE_CNT_W'(TRACE_DEPTH));
    assign do_pop  = pop & (count != '0);   // pop on empty is ignored
    assign do_push = push & (!full | do_pop);  // full with pop still takes it

    ////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // dropped push sets the flag, set beats clear
    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push && !do_push) begin
            overflow <= 1'b1;
        end else if (ovf_clr) begin
            overflow <= 1'b0;
        end
    end

    // storage
    always_ff @(posedge tcb) begin
        if (do_push) begin
            mem[wr_ptr] <= rec;
        end
    end

    assign head = mem[rd_ptr];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_cnt_max: assert property (
        @(posedge tcb) disable iff (!rst_n)
        count <= TRACE_CNT_W'(TRACE_DEPTH)
    ) else $error("count above depth");

endmodule

/* hdl/trace_apb_port.sv */
`timescale 1ns/1ns

module trace_apb_port import trace_pkg::*; (
    input  logic                   tcb,
    input  logic                   rst_n,
    input  apb_req_t               apb_req,
    output apb_rsp_t               apb_rsp,
    input  trace_rec_t             head,      // FIFO head record
    input  logic [TRACE_CNT_W-1:0] count,
    input  logic                   overflow,
    output logic                   pop,       // single cycle pulse
    output logic                   ovf_clr,   // single cycle pulse
    output logic                   ena        // to collector
);

    ////////////////////////////////////////
    // access decode
    ////////////////////////////////////////

    logic access;   // APB access phase
    logic wr;
    logic rd;
    logic empty;
    logic mapped;   // offset hits a register

    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;
    assign rd     = access & !apb_req.pwrite;
    assign empty  = (count == '0);

    always_comb begin
        case (apb_req.paddr)
            REG_STATUS, REG_CTRL, REG_POP,
            REG_PC, REG_INS, REG_FLAGS,
            REG_WB_DAT, REG_LS_ADR, REG_LS_DAT: mapped = 1'b1;
            default:                            mapped = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            ena <= 1'b0;
        end else if (wr && apb_req.paddr == REG_CTRL) begin
            ena <= apb_req.pwdata[CTRL_ENA];
        end
    end

    // no wait states, so the access phase lasts one cycle
    assign pop     = wr & (apb_req.paddr == REG_POP);  // any data
    assign ovf_clr = wr & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[CTRL_OVF_CLR];

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////

    always_comb begin
        apb_rsp.prdata = '0;
        if (rd) begin
            case (apb_req.paddr)
                REG_STATUS: begin
                    apb_rsp.prdata = {{(XLEN-8){1'b0}}, count, 2'b00, overflow, empty};
                end
                REG_CTRL: begin
                    apb_rsp.prdata[CTRL_ENA] = ena;  // clear bit reads 0
                end
                REG_PC: begin
                    apb_rsp.prdata = head.pc;
                end
                REG_INS: begin
                    apb_rsp.prdata = head.ins;
                end
                REG_FLAGS: begin
                    apb_rsp.prdata = {{(XLEN-12){1'b0}},
                                      head.ls_siz, head.ls_wen, head.ls_vld,
                                      2'b00, head.wb_idx, head.wb_vld};
                end
                REG_WB_DAT: begin
                    apb_rsp.prdata = head.wb_dat;
                end
                REG_LS_ADR: begin
                    apb_rsp.prdata = head.ls_adr;
                end
                REG_LS_DAT: begin
                    apb_rsp.prdata = head.ls_dat;
                end
                default: begin
                    apb_rsp.prdata = '0;  // POP and holes read zero
                end
            endcase
        end
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & !mapped;  // unmapped offset

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // access phase must follow a setup phase
    a_apb_setup: assert property (
        @(posedge tcb) disable iff (!rst_n)
        apb_req.psel && apb_req.penable |-> $past(apb_req.psel && !apb_req.penable)
    ) else $error("access without setup");

endmodule

/* hdl/trace_unit.sv */
`timescale 1ns/1ns

module trace_unit import trace_pkg::*; (
    input  logic     tcb,
    input  logic     rst_n,
    input  tcb_req_t tcb_req,   // core port, monitored
    input  tcb_rsp_t tcb_rsp,   // from memory model
    input  apb_req_t apb_req,   // host register port
    output apb_rsp_t apb_rsp
);

    logic                   push;
    trace_rec_t             rec;      // collector to FIFO
    trace_rec_t             head;     // FIFO to APB
    logic [TRACE_CNT_W-1:0] count;
    logic                   overflow;
    logic                   pop;
    logic                   ovf_clr;
    logic                   ena;

    ////////////////////////////////////////
    // producer, buffer, consumer
    ////////////////////////////////////////

    trace_collector u_collector (
        .tcb (tcb), .rst_n (rst_n),
        .req (tcb_req), .rsp (tcb_rsp),
        .ena (ena), .push (push), .rec (rec)
    );

    trace_fifo u_fifo (
        .tcb (tcb), .rst_n (rst_n),
        .push (push), .rec (rec), .pop (pop), .ovf_clr (ovf_clr),
        .head (head), .count (count), .overflow (overflow)
    );

    trace_apb_port u_apb (
        .tcb (tcb), .rst_n (rst_n),
        .apb_req (apb_req), .apb_rsp (apb_rsp),
        .head (head), .count (count), .overflow (overflow),
        .pop (pop), .ovf_clr (ovf_clr), .ena (ena)
    );

endmodule

/* bench/trace_tb.sv */
`timescale 1ns/1ns

module trace_tb import trace_pkg::*; ();

    localparam int HALF_PERIOD = 20;   // 40 ns clock
    localparam int TEST_CNT    = 6;
    localparam int TEST_CYCLES = 400;  // budget per test
    localparam int POLL_MAX    = 50;

    logic     tcb;
    logic     rst_n;
    tcb_req_t tcb_req;   // core side, driven here
    tcb_rsp_t tcb_rsp;   // memory model side
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // expected side, built from the retirement rules
    trace_rec_t exp_q[$];  // mirrors FIFO contents
    trace_rec_t m_cur;     // instruction in progress
    logic       m_open;
    logic       m_ena;
    logic       m_ovf;

    int err_cnt;
    int chk_cnt;
    int test_err0;  // errors before the running test

    trace_unit uut (
        .tcb     (tcb),
        .rst_n   (rst_n),
        .tcb_req (tcb_req),
        .tcb_rsp (tcb_rsp),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #HALF_PERIOD tcb = ~tcb;

    initial begin : watchdog
        #(TEST_CNT * TEST_CYCLES * 2 * HALF_PERIOD);
        $display("timed out at %0t, a test never finished", $time);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // core side
    ////////////////////////////////////////

    // one phased transfer, entered and left just after a falling edge
    task automatic bus_xfer(input logic [2:0] pha, input logic wen, input logic [1:0] siz,
                            input logic [XLEN-1:0] adr, wdt, rdt, input int stl);
        tcb_req.vld = 1'b1;
        tcb_req.pha = pha;
        tcb_req.wen = wen;
        tcb_req.siz = siz;
        tcb_req.adr = adr;
        tcb_req.wdt = wdt;
        tcb_rsp.rdy = (stl == 0);
        repeat (stl) @(negedge tcb);  // held request, no transfer
        tcb_rsp.rdy = 1'b1;
        @(negedge tcb);               // handshake on the rising edge in between
        tcb_req.vld = 1'b0;
        tcb_rsp.rdt = rdt;            // read data lags one cycle
    endtask

    function automatic int pick_stall(input int max_stl);
        if (max_stl == 0) return 0;
        return $urandom_range(max_stl, 0);
    endfunction

    task automatic fetch(input logic [XLEN-1:0] pc, ins, input int stl = 0);
        // next fetch retires the open instruction
        if (m_open && m_ena) begin
            if (exp_q.size() < TRACE_DEPTH) begin
                exp_q.push_back(m_cur);
            end else begin
                m_ovf = 1'b1;  // dropped
            end
        end
        m_cur     = '0;
        m_cur.pc  = pc;
        m_cur.ins = ins;
        m_open    = 1'b1;
        bus_xfer(PHA_IF, 1'b0, 2'd2, pc, '0, ins, stl);
    endtask

    task automatic rs_read(input logic [2:0] pha, input logic [4:0] idx,
                           input logic [XLEN-1:0] dat, input int stl = 0);
        bus_xfer(pha, 1'b0, 2'd2, XLEN'({idx, 2'b00}), '0, dat, stl);  // not logged
    endtask

    task automatic writeback(input logic [4:0] idx, input logic [XLEN-1:0] dat,
                             input int stl = 0);
        m_cur.wb_vld = 1'b1;
        m_cur.wb_idx = idx;
        m_cur.wb_dat = dat;
        bus_xfer(PHA_WB, 1'b1, 2'd2, XLEN'({idx, 2'b00}), dat, '0, stl);
    endtask

    task automatic load(input logic [XLEN-1:0] adr, input logic [1:0] siz,
                        input logic [XLEN-1:0] dat, input int stl = 0);
        m_cur.ls_vld = 1'b1;
        m_cur.ls_wen = 1'b0;
        m_cur.ls_siz = siz;
        m_cur.ls_adr = adr;
        m_cur.ls_dat = dat;  // memory returns this
        bus_xfer(PHA_MLD, 1'b0, siz, adr, '0, dat, stl);
    endtask

    task automatic store(input logic [XLEN-1:0] adr, input logic [1:0] siz,
                         input logic [XLEN-1:0] dat, input int stl = 0);
        m_cur.ls_vld = 1'b1;
        m_cur.ls_wen = 1'b1;
        m_cur.ls_siz = siz;
        m_cur.ls_adr = adr;
        m_cur.ls_dat = dat;
        bus_xfer(PHA_MST, 1'b1, siz, adr, dat, '0, stl);
    endtask

    // kind 0 alu, 1 load, 2 store; each phase gets its own random stall
    task automatic run_instr(input int kind, input logic [XLEN-1:0] pc, ins, adr, dat,
                             input int max_stl);
        fetch(pc, ins, pick_stall(max_stl));
        rs_read(PHA_RS1, ins[19:15], dat ^ 32'h5a5a_5a5a, pick_stall(max_stl));
        case (kind)
            1: begin
                load(adr, ins[13:12], dat, pick_stall(max_stl));
                writeback(ins[11:7], dat, pick_stall(max_stl));
            end
            2: begin
                rs_read(PHA_RS2, ins[24:20], dat, pick_stall(max_stl));
                store(adr, ins[13:12], dat, pick_stall(max_stl));  // no wb
            end
            default: begin
                rs_read(PHA_RS2, ins[24:20], ~dat, pick_stall(max_stl));
                writeback(ins[11:7], dat + 1, pick_stall(max_stl));  // alu result
            end
        endcase
    endtask

    ////////////////////////////////////////
    // host side
    ////////////////////////////////////////

    task automatic apb_write(input logic [7:0] adr, input logic [XLEN-1:0] dat);
        apb_req.psel    = 1'b1;  // setup
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = adr;
        apb_req.pwdata  = dat;
        @(negedge tcb);
        apb_req.penable = 1'b1;  // access, no wait states
        @(negedge tcb);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] adr, output apb_rsp_t rsp);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = adr;
        @(negedge tcb);
        apb_req.penable = 1'b1;
        #(HALF_PERIOD / 2);  // mid low phase, prdata settled
        rsp = apb_rsp;
        check_word(XLEN'(1'b1), XLEN'(rsp.pready), "pready");  // never a wait state
        @(negedge tcb);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic check_word(input logic [XLEN-1:0] exp, got, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    // six record words, fields behind a clear valid are don't care
    task automatic check_rec(input trace_rec_t exp);
        apb_rsp_t        r;
        logic [XLEN-1:0] flags;
        apb_read(REG_PC, r);
        check_word(exp.pc, r.prdata, "record pc");
        apb_read(REG_INS, r);
        check_word(exp.ins, r.prdata, "record ins");
        apb_read(REG_FLAGS, r);
        flags = r.prdata;
        check_word(XLEN'(exp.wb_vld), XLEN'(flags[0]), "wb_vld");
        check_word(XLEN'(exp.ls_vld), XLEN'(flags[8]), "ls_vld");
        apb_read(REG_WB_DAT, r);
        if (exp.wb_vld) begin
            check_word(XLEN'(exp.wb_idx), XLEN'(flags[5:1]), "wb_idx");
            check_word(exp.wb_dat, r.prdata, "wb_dat");
        end
        apb_read(REG_LS_ADR, r);
        if (exp.ls_vld) begin
            check_word(XLEN'(exp.ls_wen), XLEN'(flags[9]), "ls_wen");
            check_word(XLEN'(exp.ls_siz), XLEN'(flags[11:10]), "ls_siz");
            check_word(exp.ls_adr, r.prdata, "ls_adr");
        end
        apb_read(REG_LS_DAT, r);
        if (exp.ls_vld) begin
            check_word(exp.ls_dat, r.prdata, "ls_dat");
        end
    endtask

    task automatic check_status(input logic [TRACE_CNT_W-1:0] cnt, input logic ovf);
        apb_rsp_t r;
        apb_read(REG_STATUS, r);
        check_word({{(XLEN-8){1'b0}}, cnt, 2'b00, ovf, cnt == '0}, r.prdata, "status");
    endtask

    task automatic check_slverr(input logic [7:0] adr, input logic exp);
        apb_rsp_t r;
        apb_read(adr, r);
        chk_cnt++;
        if (r.pslverr !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: pslverr at offset %h expected %b got %b",
                     $time, adr, exp, r.pslverr);
        end
    endtask

    // poll STATUS until the FIFO holds a record
    task automatic wait_record();
        apb_rsp_t r;
        int       polls = 0;
        do begin
            apb_read(REG_STATUS, r);
            polls++;
        end while (r.prdata[0] && polls < POLL_MAX);
        if (r.prdata[0]) begin
            err_cnt++;
            $display("no trace record reached the FIFO after %0d status polls", polls);
        end
    endtask

    // pop every expected record, oldest first
    task automatic drain_check();
        trace_rec_t exp;
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            wait_record();
            check_rec(exp);
            apb_write(REG_POP, $urandom);  // any data pops
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-12s done, %0d errors", name, err_cnt - test_err0);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset();
        apb_rsp_t r;
        test_err0 = err_cnt;
        check_status('0, 1'b0);
        apb_read(REG_CTRL, r);
        check_word('0, r.prdata, "ctrl after reset");
        for (int i = 0; i < 3; i++) begin
            fetch($urandom & 32'hffff_fffc, $urandom);  // tracing still off
        end
        check_status('0, 1'b0);
        report_test("reset");
    endtask

    task automatic test_alu();
        test_err0 = err_cnt;
        apb_write(REG_CTRL, 32'h1);
        m_ena = 1'b1;
        run_instr(0, 32'h0000_1000, $urandom, '0, $urandom, 0);
        fetch(32'h0000_1004, $urandom);  // retires the alu op
        drain_check();
        check_status('0, 1'b0);
        report_test("alu");
    endtask

    task automatic test_load_store();
        test_err0 = err_cnt;
        run_instr(1, 32'h0000_2000, $urandom, $urandom, $urandom, 0);
        run_instr(2, 32'h0000_2004, $urandom, $urandom, $urandom, 0);
        fetch(32'h0000_2008, $urandom);
        drain_check();
        check_status('0, 1'b0);
        report_test("load_store");
    endtask

    // same sequence twice, plain then with stalls
    task automatic test_stalls();
        logic [XLEN-1:0] pcs  [4];
        logic [XLEN-1:0] inss [4];
        logic [XLEN-1:0] adrs [4];
        logic [XLEN-1:0] dats [4];
        test_err0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            pcs[i]  = $urandom & 32'hffff_fffc;
            inss[i] = $urandom;
            adrs[i] = $urandom;
            dats[i] = $urandom;
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 4; i++) begin
                run_instr(i % 3, pcs[i], inss[i], adrs[i], dats[i], pass * 3);
            end
            drain_check();
        end
        check_status('0, 1'b0);
        report_test("stalls");
    endtask

    task automatic test_overflow();
        test_err0 = err_cnt;
        for (int i = 0; i < 10; i++) begin
            run_instr(i % 3, $urandom & 32'hffff_fffc, $urandom, $urandom, $urandom, 0);
        end
        check_status(TRACE_CNT_W'(exp_q.size()), m_ovf);  // full and flagged
        drain_check();
        check_status('0, m_ovf);
        apb_write(REG_CTRL, 32'h3);  // keep enable, clear flag
        m_ovf = 1'b0;
        check_status('0, 1'b0);
        report_test("overflow");
    endtask

    task automatic test_errors();
        test_err0 = err_cnt;
        check_slverr(8'h0C, 1'b1);  // hole in the map
        check_slverr(8'h40, 1'b1);
        check_slverr(REG_STATUS, 1'b0);
        apb_write(REG_POP, '0);     // pop on empty
        check_status('0, 1'b0);
        report_test("errors");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : main
        void'($urandom(7));
        tcb         = 1'b0;
        rst_n       = 1'b0;
        tcb_req     = '0;
        tcb_rsp     = '0;
        tcb_rsp.rdy = 1'b1;  // memory ready when idle
        apb_req     = '0;
        m_cur       = '0;
        m_open      = 1'b0;
        m_ena       = 1'b0;
        m_ovf       = 1'b0;
        err_cnt     = 0;
        chk_cnt     = 0;
        test_err0   = 0;
        repeat (5) @(negedge tcb);
        rst_n = 1'b1;
        @(negedge tcb);
        test_reset();
        test_alu();
        test_load_store();
        test_stalls();
        test_overflow();
        test_errors();
        $display("tests %0d, checks %0d, errors %0d", TEST_CNT, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
hdl/trace_pkg.sv
hdl/trace_collector.sv
hdl/trace_fifo.sv
hdl/trace_apb_port.sv
hdl/trace_unit.sv
bench/trace_tb.sv
